//--- bench/dbg_assertions.sv
module dbg_assertions (
    input logic clk,
    input logic rst_n,
    input logic dmi_req,
    input logic dmi_resp,
    input logic mem_req
);

    // one response per request, exactly one cycle later
    resp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        dmi_req |=> dmi_resp)
        else $error("dmi_resp did not follow dmi_req by one cycle");

    resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        dmi_resp |-> $past(dmi_req))
        else $error("dmi_resp without a dmi_req one cycle earlier");

    mem_req_single: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |=> !mem_req)
        else $error("mem_req high for two cycles in a row");

    mem_req_reset: assert property (@(posedge clk)
        !rst_n |=> !mem_req)
        else $error("mem_req high while in reset");

    // a new request while the dm still owes a response
    no_req_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        dmi_req |=> !dmi_req)
        else $error("dmi_req while a response is pending");

endmodule

bind dbg_top dbg_assertions u_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .dmi_req  (dmi_req),
    .dmi_resp (dmi_resp),
    .mem_req  (mem_req)
);

//--- bench/dbg_tb.sv
`include "dbg_config.svh"

module dbg_tb import dbg_pkg::*; ();

    localparam int DMI_W      = `DBG_ABITS + 34;
    localparam int POLL_LIMIT = 50;

    localparam dmaddr_t A_DMCONTROL  = 'h10;
    localparam dmaddr_t A_DMSTATUS   = 'h11;
    localparam dmaddr_t A_SBCS       = 'h38;
    localparam dmaddr_t A_SBADDRESS0 = 'h39;
    localparam dmaddr_t A_SBDATA0    = 'h3C;

    logic        clk;
    logic        rst_n;
    logic        tck;
    logic        tms;
    logic        tdi;
    logic        tdo;
    logic [31:0] lfsr;
    data_t       model [addr_t];
    logic        sh_haltreq;
    logic        sh_resumereq;
    logic [19:0] sh_hartsel;
    int          test_errs;
    int          op_errs;
    int          scan_count;
    int          tests_pass;
    int          tests_fail;

    dbg_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .tck   (tck),
        .tms   (tms),
        .tdi   (tdi),
        .tdo   (tdo)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task rand_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // hartsello sits in 25:16, hartselhi in 15:6
    function automatic logic [19:0] hartsel_field(input logic [19:0] index);
        return {index[9:0], index[19:10]};
    endfunction

    function automatic data_t ctl_word();
        return {sh_haltreq, sh_resumereq, 4'd0, sh_hartsel, 5'd0, 1'b1};
    endfunction

    task check_eq(input string name, input data_t exp, input data_t act);
        assert (act === exp) else begin
            $display("ERR t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            tests_pass++;
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_fail++;
        end
        test_errs = 0;
    endtask

    // one tck period, tdo read at the end of the low phase
    task tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tms = tms_v;
        tdi = tdi_v;
        tck = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        tck = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        tdo_v = tdo;
    endtask

    task tap_reset();
        logic b;
        repeat (5) tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
    endtask

    task idle(input int n);
        logic b;
        repeat (n) tck_cycle(1'b0, 1'b0, b);
    endtask

    task ir_scan(input logic [`DBG_IR_W-1:0] ir_val);
        logic b;
        int   i;
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
        for (i = 0; i < `DBG_IR_W; i++) begin
            tck_cycle(i == `DBG_IR_W - 1, ir_val[i], b);
        end
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
    endtask

    task dr_scan(input logic [63:0] din, input int len, output logic [63:0] dout);
        logic b;
        int   i;
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
        // entering shift-dr puts captured bit 0 on tdo
        tck_cycle(1'b0, 1'b0, b);
        dout    = '0;
        dout[0] = b;
        for (i = 0; i < len; i++) begin
            tck_cycle(i == len - 1, din[i], b);
            if (i < len - 1) begin
                dout[i + 1] = b;
            end
        end
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
    endtask

    task dmi_scan(input dmaddr_t addr, input data_t data, input dmi_op_t op,
                  output data_t rdata);
        logic [63:0] din;
        logic [63:0] dout;
        din = '0;
        din[DMI_W-1:0] = {addr, data, op};
        dr_scan(din, DMI_W, dout);
        assert (dout[1:0] == 2'b00) else begin
            $display("ERR t=%0t dmi.op expected 0 actual %0d", $time, dout[1:0]);
            op_errs++;
        end
        scan_count++;
        rdata = dout[33:2];
        idle(1);
    endtask

    task dm_write(input dmaddr_t addr, input data_t data);
        data_t unused_rd;
        dmi_scan(addr, data, DMI_OP_WRITE, unused_rd);
    endtask

    // the read result shows up in the capture of the following scan
    task dm_read(input dmaddr_t addr, output data_t data);
        data_t first;
        dmi_scan(addr, 32'd0, DMI_OP_READ, first);
        dmi_scan(addr, 32'd0, DMI_OP_NOP, data);
    endtask

    task wait_bit(input dmaddr_t addr, input int bit_idx, input logic want,
                  input string what);
        data_t val;
        int    tries;
        logic  done;
        done = 1'b0;
        for (tries = 0; tries < POLL_LIMIT && !done; tries++) begin
            dm_read(addr, val);
            done = (val[bit_idx] == want);
        end
        assert (done) else begin
            $display("timeout waiting for %s after %0d DMI reads", what, POLL_LIMIT);
            test_errs++;
        end
    endtask

    task sb_write(input addr_t addr, input data_t data);
        dm_write(A_SBCS, 32'd0);
        dm_write(A_SBADDRESS0, addr);
        dm_write(A_SBDATA0, data);
        wait_bit(A_SBCS, 21, 1'b0, "sbbusy to clear after a bus write");
    endtask

    task sb_read(input addr_t addr, output data_t data);
        dm_write(A_SBCS, 32'd1 << 20);
        dm_write(A_SBADDRESS0, addr);
        wait_bit(A_SBCS, 21, 1'b0, "sbbusy to clear after a bus read");
        dm_read(A_SBDATA0, data);
    endtask

    task halt();
        sh_haltreq   = 1'b1;
        sh_resumereq = 1'b0;
        dm_write(A_DMCONTROL, ctl_word());
        wait_bit(A_DMSTATUS, 9, 1'b1, "allhalted");
    endtask

    task resume();
        data_t st;
        sh_haltreq = 1'b0;
        dm_write(A_DMCONTROL, ctl_word());
        sh_resumereq = 1'b1;
        dm_write(A_DMCONTROL, ctl_word());
        wait_bit(A_DMSTATUS, 17, 1'b1, "allresumeack");
        dm_read(A_DMSTATUS, st);
        check_eq("dmstatus.allhalted", 32'd0, {31'd0, st[9]});
        sh_resumereq = 1'b0;
        dm_write(A_DMCONTROL, ctl_word());
    endtask

    initial begin
        logic [63:0] dout;
        logic [31:0] r;
        data_t       rd;
        data_t       wd;
        addr_t       a;
        addr_t       tmp;
        addr_t       addrs[$];
        addr_t       order[$];
        int          i;
        int          j;
        logic        found;

        rst_n        = 1'b0;
        tck          = 1'b0;
        tms          = 1'b0;
        tdi          = 1'b0;
        lfsr         = 32'd7834;
        sh_haltreq   = 1'b0;
        sh_resumereq = 1'b0;
        sh_hartsel   = '0;
        test_errs    = 0;
        op_errs      = 0;
        scan_count   = 0;
        tests_pass   = 0;
        tests_fail   = 0;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        tap_reset();
        dr_scan(64'd0, 32, dout);
        check_eq("idcode", `DBG_IDCODE, dout[31:0]);
        ir_scan(`DBG_IR_W'('h10));
        dr_scan(64'd0, 32, dout);
        check_eq("dtmcs", (32'd1 << 12) | (32'(`DBG_ABITS) << 4) | 32'd1, dout[31:0]);
        finish_test("1 idcode and dtmcs");
        ir_scan(`DBG_IR_W'('h11));

        dm_write(A_DMCONTROL, 32'd1);
        rand_bits(20, r);
        sh_hartsel = r[19:0];
        dm_write(A_DMCONTROL, ctl_word());
        dm_read(A_DMCONTROL, rd);
        check_eq("dmcontrol", ctl_word(), rd);
        sh_hartsel = hartsel_field(20'd2);
        dm_write(A_DMCONTROL, ctl_word());
        dm_read(A_DMSTATUS, rd);
        check_eq("dmstatus.allnonexistent", 32'd1, {31'd0, rd[15]});
        check_eq("dmstatus.allhalted", 32'd0, {31'd0, rd[9]});
        finish_test("2 dmcontrol and hartsel");

        sh_hartsel = hartsel_field(20'd1);
        halt();
        resume();
        finish_test("3 halt and resume");

        for (i = 0; i < 20; i++) begin
            // every fifth write lands on an earlier address
            if (i % 5 == 4) begin
                a = addrs[i - 3];
            end else begin
                rand_bits(10, r);
                a = {20'd0, r[9:0], 2'b00};
            end
            rand_bits(32, wd);
            sb_write(a, wd);
            model[a] = wd;
            addrs.push_back(a);
        end
        foreach (model[k]) begin
            order.push_back(k);
        end
        for (i = order.size() - 1; i > 0; i--) begin
            rand_bits(16, r);
            j = int'(r % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < order.size(); i++) begin
            sb_read(order[i], rd);
            check_eq("sbdata0", model[order[i]], rd);
        end
        finish_test("4 bus writes and shuffled reads");

        found = 1'b0;
        for (i = 0; i < POLL_LIMIT && !found; i++) begin
            rand_bits(10, r);
            a     = {20'd0, r[9:0], 2'b00};
            found = !model.exists(a);
        end
        if (found) begin
            sb_read(a, rd);
            check_eq("sbdata0 unwritten", 32'd0, rd);
        end else begin
            $display("no unwritten address found for the read of fresh memory");
            test_errs++;
        end
        finish_test("5 read of unwritten memory");

        test_errs = op_errs;
        finish_test($sformatf("6 dmi op status over %0d scans", scan_count));

        $display("summary: %0d tests passed, %0d tests failed", tests_pass, tests_fail);
        if (tests_fail == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- common/dbg_config.svh
`ifndef DBG_CONFIG_SVH
`define DBG_CONFIG_SVH

// tap idcode, bit 0 must be 1
`define DBG_IDCODE 32'h1000_0DB3

// instruction register width
`define DBG_IR_W 5

// dmi address width, also reported in dtmcs.abits
`define DBG_ABITS 7

// system memory size in 32-bit words
`define DBG_MEM_WORDS 1024

// cycles the hart stub needs to halt or resume
`define DBG_HALT_DELAY 4

`endif

//--- common/dbg_pkg.sv
`include "dbg_config.svh"

package dbg_pkg;

    typedef logic [31:0]             addr_t;
    typedef logic [31:0]             data_t;
    typedef logic [`DBG_ABITS-1:0]   dmaddr_t;
    typedef logic [1:0]              dmi_op_t;

    localparam dmi_op_t DMI_OP_NOP   = 2'd0;
    localparam dmi_op_t DMI_OP_READ  = 2'd1;
    localparam dmi_op_t DMI_OP_WRITE = 2'd2;

    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        TAP_SEL_DR,
        TAP_CAP_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPD_DR,
        TAP_SEL_IR,
        TAP_CAP_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPD_IR
    } tap_state_t;

    typedef enum logic [1:0] {
        SB_IDLE,
        SB_ISSUE,
        SB_WAIT
    } sb_state_t;

endpackage

//--- debug_module/debug_module.sv
`include "dbg_config.svh"

module debug_module import dbg_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    dmi_req,
    input  dmaddr_t dmi_addr,
    input  data_t   dmi_wdata,
    input  dmi_op_t dmi_op,
    output logic    dmi_resp,
    output data_t   dmi_rdata,
    output logic    mem_req,
    output logic    mem_we,
    output addr_t   mem_addr,
    output data_t   mem_wdata,
    input  data_t   mem_rdata
);

    localparam dmaddr_t A_DMCONTROL  = 'h10;
    localparam dmaddr_t A_DMSTATUS   = 'h11;
    localparam dmaddr_t A_SBCS       = 'h38;
    localparam dmaddr_t A_SBADDRESS0 = 'h39;
    localparam dmaddr_t A_SBDATA0    = 'h3C;

    localparam int CNT_W = $clog2(`DBG_HALT_DELAY + 1);

    logic               dmactive;
    logic               haltreq;
    logic               resumereq;
    logic [19:0]        hartsel;
    logic [19:0]        hart_index;
    logic               hart_ok;
    logic               halted;
    logic               resumeack;
    logic [CNT_W-1:0]   hart_cnt;
    logic               halt_pend;
    logic               resume_pend;
    logic               sbreadonaddr;
    sb_state_t          sb_state;
    logic               sb_we;
    addr_t              sbaddress0;
    data_t              sbdata0;
    logic               dm_wr;
    logic               dm_rd;
    logic               reg_wr;
    data_t              dmcontrol_rd;
    data_t              dmstatus_rd;
    data_t              sbcs_rd;
    data_t              rd_mux;

    assign dm_wr = dmi_req && (dmi_op == DMI_OP_WRITE);
    assign dm_rd = dmi_req && (dmi_op == DMI_OP_READ);

    // bus registers only take writes while active and not busy
    assign reg_wr = dm_wr && dmactive && (sb_state == SB_IDLE);

    // 25:16 is hartsello, 15:6 is hartselhi
    assign hart_index = {hartsel[9:0], hartsel[19:10]};
    assign hart_ok    = (hart_index == 20'd1);

    assign halt_pend   = haltreq && hart_ok && !halted;
    assign resume_pend = resumereq && !haltreq && hart_ok && halted;

    assign dmcontrol_rd = {haltreq, resumereq, 4'd0, hartsel, 5'd0, dmactive};

    always_comb begin
        dmstatus_rd      = '0;
        dmstatus_rd[3:0] = 4'd2;
        dmstatus_rd[7]   = 1'b1;
        if (hart_ok) begin
            dmstatus_rd[17:16] = {2{resumeack}};
            dmstatus_rd[11:10] = {2{!halted}};
            dmstatus_rd[9:8]   = {2{halted}};
        end else begin
            dmstatus_rd[15:14] = 2'b11;
        end
    end

    // sbversion 1, 32-bit access, 32-bit address
    assign sbcs_rd = {3'd1, 7'd0, (sb_state != SB_IDLE), sbreadonaddr, 3'd2,
                      5'd0, 7'd32, 5'b00100};

    always_comb begin
        case (dmi_addr)
            A_DMCONTROL:  rd_mux = dmcontrol_rd;
            A_DMSTATUS:   rd_mux = dmstatus_rd;
            A_SBCS:       rd_mux = sbcs_rd;
            A_SBADDRESS0: rd_mux = sbaddress0;
            A_SBDATA0:    rd_mux = sbdata0;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmi_resp     <= 1'b0;
            dmactive     <= 1'b0;
            haltreq      <= 1'b0;
            resumereq    <= 1'b0;
            hartsel      <= '0;
            halted       <= 1'b0;
            resumeack    <= 1'b0;
            hart_cnt     <= '0;
            sbreadonaddr <= 1'b0;
            sb_state     <= SB_IDLE;
        end else begin
            dmi_resp <= dmi_req;
            if (dm_wr && dmi_addr == A_DMCONTROL) begin
                dmactive <= dmi_wdata[0];
                // the activating write only sets dmactive
                if (dmactive && dmi_wdata[0]) begin
                    haltreq   <= dmi_wdata[31];
                    resumereq <= dmi_wdata[30];
                    hartsel   <= dmi_wdata[25:6];
                    if (dmi_wdata[31]) begin
                        resumeack <= 1'b0;
                    end
                end else begin
                    haltreq   <= 1'b0;
                    resumereq <= 1'b0;
                    hartsel   <= '0;
                end
            end
            // hart stub countdown
            if (halt_pend || resume_pend) begin
                if (hart_cnt == CNT_W'(`DBG_HALT_DELAY - 1)) begin
                    hart_cnt <= '0;
                    halted   <= halt_pend;
                    if (resume_pend) begin
                        resumeack <= 1'b1;
                    end
                end else begin
                    hart_cnt <= hart_cnt + 1'b1;
                end
            end else begin
                hart_cnt <= '0;
            end
            if (reg_wr && dmi_addr == A_SBCS) begin
                sbreadonaddr <= dmi_wdata[20];
            end
            case (sb_state)
                SB_IDLE: begin
                    if (reg_wr && (dmi_addr == A_SBDATA0 ||
                                   (dmi_addr == A_SBADDRESS0 && sbreadonaddr))) begin
                        sb_state <= SB_ISSUE;
                    end
                end
                SB_ISSUE: sb_state <= SB_WAIT;
                SB_WAIT:  sb_state <= SB_IDLE;
                default:  sb_state <= SB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        dmi_rdata <= dm_rd ? rd_mux : '0;
        if (reg_wr && dmi_addr == A_SBADDRESS0) begin
            sbaddress0 <= dmi_wdata;
            sb_we      <= 1'b0;
        end
        if (reg_wr && dmi_addr == A_SBDATA0) begin
            sbdata0 <= dmi_wdata;
            sb_we   <= 1'b1;
        end
        // read data lands one cycle after the strobe
        if (sb_state == SB_WAIT && !sb_we) begin
            sbdata0 <= mem_rdata;
        end
    end

    assign mem_req   = (sb_state == SB_ISSUE);
    assign mem_we    = sb_we;
    assign mem_addr  = sbaddress0;
    assign mem_wdata = sbdata0;

endmodule

//--- hdl/dbg_top.sv
module dbg_top import dbg_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    output logic tdo
);

    logic    dmi_req;
    dmaddr_t dmi_addr;
    data_t   dmi_wdata;
    dmi_op_t dmi_op;
    logic    dmi_resp;
    data_t   dmi_rdata;

    logic    mem_req;
    logic    mem_we;
    addr_t   mem_addr;
    data_t   mem_wdata;
    data_t   mem_rdata;

    jtag_dtm u_dtm (
        .clk       (clk),
        .rst_n     (rst_n),
        .tck       (tck),
        .tms       (tms),
        .tdi       (tdi),
        .tdo       (tdo),
        .dmi_req   (dmi_req),
        .dmi_addr  (dmi_addr),
        .dmi_wdata (dmi_wdata),
        .dmi_op    (dmi_op),
        .dmi_resp  (dmi_resp),
        .dmi_rdata (dmi_rdata)
    );

    debug_module u_dm (
        .clk       (clk),
        .rst_n     (rst_n),
        .dmi_req   (dmi_req),
        .dmi_addr  (dmi_addr),
        .dmi_wdata (dmi_wdata),
        .dmi_op    (dmi_op),
        .dmi_resp  (dmi_resp),
        .dmi_rdata (dmi_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    sys_mem u_mem (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- hdl/sys_mem.sv
`include "dbg_config.svh"

module sys_mem import dbg_pkg::*; (
    input  logic  clk,
    input  logic  mem_req,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  data_t mem_wdata,
    output data_t mem_rdata
);

    localparam int IDX_W = $clog2(`DBG_MEM_WORDS);

    data_t            mem [`DBG_MEM_WORDS];
    logic [IDX_W-1:0] idx;

    // word index, byte offset dropped
    assign idx = mem_addr[IDX_W+1:2];

    initial begin
        for (int i = 0; i < `DBG_MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (mem_req) begin
            if (mem_we) begin
                mem[idx] <= mem_wdata;
            end else begin
                mem_rdata <= mem[idx];
            end
        end
    end

endmodule

//--- jtag_dtm/jtag_dtm.sv
`include "dbg_config.svh"

module jtag_dtm import dbg_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    tck,
    input  logic    tms,
    input  logic    tdi,
    output logic    tdo,
    output logic    dmi_req,
    output dmaddr_t dmi_addr,
    output data_t   dmi_wdata,
    output dmi_op_t dmi_op,
    input  logic    dmi_resp,
    input  data_t   dmi_rdata
);

    localparam int DMI_W = `DBG_ABITS + 34;

    localparam logic [`DBG_IR_W-1:0] IR_IDCODE = 'h01;
    localparam logic [`DBG_IR_W-1:0] IR_DTMCS  = 'h10;
    localparam logic [`DBG_IR_W-1:0] IR_DMI    = 'h11;

    // abits in 9:4, idle 1 in 14:12, version 1
    localparam data_t DTMCS_VAL = {17'd0, 3'd1, 2'd0, 6'(`DBG_ABITS), 4'd1};

    logic [2:0]             tck_sync;
    logic                   tck_rise;
    logic                   tck_fall;
    tap_state_t             tap_q;
    tap_state_t             tap_next;
    logic [`DBG_IR_W-1:0]   ir;
    logic [`DBG_IR_W-1:0]   ir_sr;
    logic [DMI_W-1:0]       dr_sr;
    data_t                  resp_data;
    logic                   dmi_update;

    // two sync flops plus one for edge detection
    assign tck_rise = tck_sync[1] & ~tck_sync[2];
    assign tck_fall = ~tck_sync[1] & tck_sync[2];

    assign dmi_update = tck_rise && (tap_q == TAP_UPD_DR) && (ir == IR_DMI);

    always_comb begin
        case (tap_q)
            TAP_RESET:    tap_next = tms ? TAP_RESET    : TAP_IDLE;
            TAP_IDLE:     tap_next = tms ? TAP_SEL_DR   : TAP_IDLE;
            TAP_SEL_DR:   tap_next = tms ? TAP_SEL_IR   : TAP_CAP_DR;
            TAP_CAP_DR:   tap_next = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR: tap_next = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR: tap_next = tms ? TAP_UPD_DR   : TAP_PAUSE_DR;
            TAP_PAUSE_DR: tap_next = tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR: tap_next = tms ? TAP_UPD_DR   : TAP_SHIFT_DR;
            TAP_UPD_DR:   tap_next = tms ? TAP_SEL_DR   : TAP_IDLE;
            TAP_SEL_IR:   tap_next = tms ? TAP_RESET    : TAP_CAP_IR;
            TAP_CAP_IR:   tap_next = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR: tap_next = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR: tap_next = tms ? TAP_UPD_IR   : TAP_PAUSE_IR;
            TAP_PAUSE_IR: tap_next = tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR: tap_next = tms ? TAP_UPD_IR   : TAP_SHIFT_IR;
            TAP_UPD_IR:   tap_next = tms ? TAP_SEL_DR   : TAP_IDLE;
            default:      tap_next = TAP_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tck_sync <= '0;
            tap_q    <= TAP_RESET;
            ir       <= IR_IDCODE;
            tdo      <= 1'b0;
            dmi_req  <= 1'b0;
        end else begin
            tck_sync <= {tck_sync[1:0], tck};
            dmi_req  <= 1'b0;
            if (tck_rise) begin
                tap_q <= tap_next;
                if (tap_q == TAP_RESET) begin
                    ir <= IR_IDCODE;
                end else if (tap_q == TAP_UPD_IR) begin
                    ir <= ir_sr;
                end
            end
            if (dmi_update) begin
                dmi_req <= (dr_sr[1:0] == DMI_OP_READ) || (dr_sr[1:0] == DMI_OP_WRITE);
            end
            // tdo moves on the falling side, sampled by the master before the next rise
            if (tck_fall) begin
                if (tap_q == TAP_SHIFT_IR) begin
                    tdo <= ir_sr[0];
                end else if (tap_q == TAP_SHIFT_DR) begin
                    tdo <= dr_sr[0];
                end else begin
                    tdo <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tck_rise) begin
            case (tap_q)
                TAP_CAP_IR: ir_sr <= 'b1;
                TAP_SHIFT_IR: ir_sr <= {tdi, ir_sr[`DBG_IR_W-1:1]};
                TAP_CAP_DR: begin
                    case (ir)
                        IR_IDCODE: dr_sr <= DMI_W'(`DBG_IDCODE);
                        IR_DTMCS:  dr_sr <= DMI_W'(DTMCS_VAL);
                        // last response, op status always 0
                        IR_DMI:    dr_sr <= {dmi_addr, resp_data, 2'b00};
                        default:   dr_sr <= '0;
                    endcase
                end
                TAP_SHIFT_DR: begin
                    case (ir)
                        IR_IDCODE, IR_DTMCS: dr_sr[31:0] <= {tdi, dr_sr[31:1]};
                        IR_DMI:              dr_sr <= {tdi, dr_sr[DMI_W-1:1]};
                        default:             dr_sr[0] <= tdi;
                    endcase
                end
                default: ;
            endcase
        end
        if (dmi_update) begin
            dmi_addr  <= dr_sr[DMI_W-1:34];
            dmi_wdata <= dr_sr[33:2];
            dmi_op    <= dr_sr[1:0];
        end
        if (dmi_resp) begin
            resp_data <= dmi_rdata;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build the debug subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dbg_tb -f src.f \
    && ./obj_dir/Vdbg_tb | tee /dev/stderr | grep -q "^Testbench passed$" \
    || exit 1
exit 0

//--- src.f
+incdir+common
common/dbg_pkg.sv
jtag_dtm/jtag_dtm.sv
debug_module/debug_module.sv
hdl/sys_mem.sv
hdl/dbg_top.sv
bench/dbg_assertions.sv
bench/dbg_tb.sv
